/* alu_op_pkg.sv */
package alu_op_pkg;

    // nop is zero so a cleared stage register reads as a bubble
    typedef enum logic [3:0] {
        NOP  = 4'd0,
        ADD  = 4'd1,
        SUB  = 4'd2,
        AND  = 4'd3,
        OR   = 4'd4,
        XOR  = 4'd5,
        SLL  = 4'd6,
        SRL  = 4'd7,
        SLT  = 4'd8,
        ADDI = 4'd9,
        LUI  = 4'd10,
        BEQ  = 4'd11,
        BNE  = 4'd12
    } alu_op_t;

    function automatic logic writes_reg(input alu_op_t op);
        return !(op inside {NOP, BEQ, BNE});
    endfunction

    function automatic logic branch_taken(input alu_op_t op, input pipe_types_pkg::data_t a,
                                          input pipe_types_pkg::data_t b);
        return (op == BEQ && a == b) || (op == BNE && a != b);
    endfunction

endpackage

/* compile.f */
+incdir+.
pipe_types_pkg.sv
alu_op_pkg.sv
lane_alu.sv
issue_stage.sv
execute_stage.sv
writeback_stage.sv
dual_issue_core.sv
dual_issue_properties.sv
tb_clock_gen.sv
tb_dual_issue.sv

/* dual_issue_core.sv */
`timescale 1ns/1ps
`include "ex_cfg.svh"

module dual_issue_core (
    input  logic                                         clk,
    input  logic                                         rst_i,
    input  logic                  [`ISSUE_WIDTH-1:0]     in_valid_i,
    input  alu_op_pkg::alu_op_t   [`ISSUE_WIDTH-1:0]     in_op_i,
    input  pipe_types_pkg::reg_addr_t [`ISSUE_WIDTH-1:0] in_rd_i,
    input  pipe_types_pkg::reg_addr_t [`ISSUE_WIDTH-1:0] in_rs1_i,
    input  pipe_types_pkg::reg_addr_t [`ISSUE_WIDTH-1:0] in_rs2_i,
    input  pipe_types_pkg::data_t [`ISSUE_WIDTH-1:0]     in_imm_i,
    input  pipe_types_pkg::pc_t   [`ISSUE_WIDTH-1:0]     in_pc_i,
    input  logic                                         pause_i,
    input  logic                                         flush_i,
    output logic                  [`ISSUE_WIDTH-1:0]     commit_valid_o,
    output pipe_types_pkg::reg_addr_t [`ISSUE_WIDTH-1:0] commit_rd_o,
    output pipe_types_pkg::data_t [`ISSUE_WIDTH-1:0]     commit_data_o,
    output pipe_types_pkg::pc_t   [`ISSUE_WIDTH-1:0]     commit_pc_o,
    output logic                                         redirect_o,
    output pipe_types_pkg::pc_t                          redirect_pc_o
);

    pipe_types_pkg::reg_addr_t [2*`ISSUE_WIDTH-1:0] rf_raddr;
    pipe_types_pkg::data_t     [2*`ISSUE_WIDTH-1:0] rf_rdata;
    logic                      [`ISSUE_WIDTH-1:0]   iss_valid;
    alu_op_pkg::alu_op_t       [`ISSUE_WIDTH-1:0]   iss_op;
    pipe_types_pkg::reg_addr_t [`ISSUE_WIDTH-1:0]   iss_rd;
    pipe_types_pkg::pc_t       [`ISSUE_WIDTH-1:0]   iss_pc;
    pipe_types_pkg::data_t     [`ISSUE_WIDTH-1:0]   iss_imm;
    pipe_types_pkg::data_t     [`ISSUE_WIDTH-1:0]   iss_a;
    pipe_types_pkg::data_t     [`ISSUE_WIDTH-1:0]   iss_b;
    logic                      [`ISSUE_WIDTH-1:0]   fwd_ex_valid;
    pipe_types_pkg::reg_addr_t [`ISSUE_WIDTH-1:0]   fwd_ex_rd;
    pipe_types_pkg::data_t     [`ISSUE_WIDTH-1:0]   fwd_ex_data;
    logic                      [`ISSUE_WIDTH-1:0]   fwd_wb_valid;
    pipe_types_pkg::reg_addr_t [`ISSUE_WIDTH-1:0]   fwd_wb_rd;
    pipe_types_pkg::data_t     [`ISSUE_WIDTH-1:0]   fwd_wb_data;
    logic                      [`ISSUE_WIDTH-1:0]   wb_valid;
    pipe_types_pkg::reg_addr_t [`ISSUE_WIDTH-1:0]   wb_rd;
    pipe_types_pkg::data_t     [`ISSUE_WIDTH-1:0]   wb_data;
    pipe_types_pkg::pc_t       [`ISSUE_WIDTH-1:0]   wb_pc;

    issue_stage u_issue_stage (
        .clk, .rst_i, .pause_i, .flush_i,
        .redirect_i     (redirect_o),
        .in_valid_i, .in_op_i, .in_rd_i, .in_rs1_i, .in_rs2_i, .in_imm_i, .in_pc_i,
        .rf_rdata_i     (rf_rdata),
        .fwd_ex_valid_i (fwd_ex_valid),
        .fwd_ex_rd_i    (fwd_ex_rd),
        .fwd_ex_data_i  (fwd_ex_data),
        .fwd_wb_valid_i (fwd_wb_valid),
        .fwd_wb_rd_i    (fwd_wb_rd),
        .fwd_wb_data_i  (fwd_wb_data),
        .rf_raddr_o     (rf_raddr),
        .iss_valid_o    (iss_valid),
        .iss_op_o       (iss_op),
        .iss_rd_o       (iss_rd),
        .iss_pc_o       (iss_pc),
        .iss_imm_o      (iss_imm),
        .iss_a_o        (iss_a),
        .iss_b_o        (iss_b)
    );

    execute_stage u_execute_stage (
        .clk, .rst_i, .pause_i, .flush_i,
        .iss_valid_i    (iss_valid),
        .iss_op_i       (iss_op),
        .iss_rd_i       (iss_rd),
        .iss_pc_i       (iss_pc),
        .iss_imm_i      (iss_imm),
        .iss_a_i        (iss_a),
        .iss_b_i        (iss_b),
        .redirect_o, .redirect_pc_o,
        .fwd_ex_valid_o (fwd_ex_valid),
        .fwd_ex_rd_o    (fwd_ex_rd),
        .fwd_ex_data_o  (fwd_ex_data),
        .fwd_wb_valid_o (fwd_wb_valid),
        .fwd_wb_rd_o    (fwd_wb_rd),
        .fwd_wb_data_o  (fwd_wb_data),
        .wb_valid_o     (wb_valid),
        .wb_rd_o        (wb_rd),
        .wb_data_o      (wb_data),
        .wb_pc_o        (wb_pc)
    );

    writeback_stage u_writeback_stage (
        .clk, .rst_i, .pause_i, .flush_i,
        .wb_valid_i     (wb_valid),
        .wb_rd_i        (wb_rd),
        .wb_data_i      (wb_data),
        .wb_pc_i        (wb_pc),
        .rf_raddr_i     (rf_raddr),
        .rf_rdata_o     (rf_rdata),
        .commit_valid_o, .commit_rd_o, .commit_data_o, .commit_pc_o
    );

endmodule

/* dual_issue_properties.sv */
`timescale 1ns/1ps
`include "ex_cfg.svh"

module dual_issue_properties (
    input logic                                  clk,
    input logic                                  rst_i,
    input logic                                  pause_i,
    input logic                                  flush_i,
    input logic                                  redirect_i,
    input logic                [`ISSUE_WIDTH-1:0] commit_valid_i,
    input logic                [`ISSUE_WIDTH-1:0] iss_valid_i,
    input alu_op_pkg::alu_op_t [`ISSUE_WIDTH-1:0] iss_op_i,
    input pipe_types_pkg::data_t [`ISSUE_WIDTH-1:0] wb_data_i
);

    a_reset_quiet: assert property (@(posedge clk)
        rst_i && $past(rst_i) |-> commit_valid_i == '0 && !redirect_i)
        else $error("commit or redirect seen during reset");

    a_redirect_single: assert property (@(posedge clk) disable iff (rst_i)
        redirect_i |=> !redirect_i)
        else $error("redirect high in two consecutive cycles");

    a_flush_quiet: assert property (@(posedge clk) disable iff (rst_i)
        $past(flush_i, 2) |-> commit_valid_i == '0)
        else $error("commit two cycles after flush");

    // branch results travel to commit as zero
    for (genvar l = 0; l < `ISSUE_WIDTH; l++) begin : g_branch
        a_branch_zero: assert property (@(posedge clk) disable iff (rst_i)
            iss_valid_i[l] && iss_op_i[l] inside {alu_op_pkg::BEQ, alu_op_pkg::BNE}
            && !pause_i && !flush_i |=> wb_data_i[l] == '0)
            else $error("branch carries nonzero data toward commit");
    end

endmodule

/* dual_issue_tests.txt */
# S pause flush, then per lane 0 and 1: valid op rd rs1 rs2 imm pc (hex)
# C rd data pc in commit order, R redirect target in order
S 0 0 1 9 01 00 00 00000005 00 1 9 02 00 00 00000003 04
S 0 0 1 9 03 00 00 00000ff0 08 1 a 04 00 00 00012345 0c
S 0 0 1 1 05 01 02 0 10 1 2 06 03 04 0 14
S 0 0 1 4 07 05 03 0 18 1 5 08 06 01 0 1c
S 0 0 1 6 09 02 01 0 20 1 7 0a 04 02 0 24
S 0 0 1 8 0b 06 01 0 28 1 8 0c 01 06 0 2c
S 0 0 1 9 01 01 00 10 30 1 1 0d 01 00 0 34
S 0 0 1 9 0e 00 00 1 38 1 9 0e 00 00 2 3c
S 0 0 1 1 0f 0e 01 0 40 1 9 00 00 00 7 44
S 0 0 1 1 10 00 0e 0 48 0 0 00 00 00 0 4c
S 0 0 1 b 00 01 0d 40 50 1 9 11 00 00 21 54
S 0 0 1 c 00 01 0d 100 58 1 9 12 00 00 33 5c
S 0 0 1 9 13 00 00 44 60 0 0 00 00 00 0 64
S 0 0 1 9 14 11 00 1 68 1 b 00 00 00 20 6c
S 0 0 1 9 15 00 00 55 70 0 0 00 00 00 0 74
S 0 0 1 1 16 14 14 0 78 0 0 00 00 00 0 7c
S 0 0 1 9 17 16 00 1 80 1 9 18 00 00 50 84
S 1 0 1 9 1f 00 00 ee 88 0 0 00 00 00 0 8c
S 1 0 0 0 00 00 00 0 90 0 0 00 00 00 0 94
S 0 0 1 1 19 17 16 0 98 1 2 1a 18 17 0 9c
S 1 0 0 0 00 00 00 0 a0 0 0 00 00 00 0 a4
S 0 0 1 5 1b 19 1a 0 a8 0 0 00 00 00 0 ac
S 0 0 1 9 1c 00 00 99 b0 1 9 01 00 00 77 b4
S 0 1 1 9 02 00 00 66 b8 0 0 00 00 00 0 bc
S 0 0 1 1 1d 01 02 0 c0 1 8 1e 02 01 0 c4
C 01 00000005 00
C 02 00000003 04
C 03 00000ff0 08
C 04 12345000 0c
C 05 00000008 10
C 06 edcbbff0 14
C 07 00000ff8 18
C 08 edcbbff5 1c
C 09 00000060 20
C 0a 02468a00 24
C 0b 00000001 28
C 0c 00000000 2c
C 01 00000015 30
C 0d 00000005 34
C 0e 00000001 38
C 0e 00000002 3c
C 0f 00000017 40
C 00 00000007 44
C 10 00000002 48
C 00 00000000 50
C 11 00000021 54
C 00 00000000 58
C 14 00000022 68
C 00 00000000 6c
C 16 00000044 78
C 17 00000045 80
C 18 00000050 84
C 19 00000089 98
C 1a 0000000b 9c
C 1d 00000018 c0
C 1e 00000001 c4
R 00000158
R 0000008c

/* ex_cfg.svh */
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// lane 0 is the older instruction of a bundle
`define ISSUE_WIDTH 2

`define DATA_W 32

// register 0 is hardwired to zero
`define REG_COUNT 32
`define REG_ADDR_W 5

`endif

/* execute_stage.sv */
`timescale 1ns/1ps
`include "ex_cfg.svh"

module execute_stage (
    input  logic                                         clk,
    input  logic                                         rst_i,
    input  logic                                         pause_i,
    input  logic                                         flush_i,
    input  logic                  [`ISSUE_WIDTH-1:0]     iss_valid_i,
    input  alu_op_pkg::alu_op_t   [`ISSUE_WIDTH-1:0]     iss_op_i,
    input  pipe_types_pkg::reg_addr_t [`ISSUE_WIDTH-1:0] iss_rd_i,
    input  pipe_types_pkg::pc_t   [`ISSUE_WIDTH-1:0]     iss_pc_i,
    input  pipe_types_pkg::data_t [`ISSUE_WIDTH-1:0]     iss_imm_i,
    input  pipe_types_pkg::data_t [`ISSUE_WIDTH-1:0]     iss_a_i,
    input  pipe_types_pkg::data_t [`ISSUE_WIDTH-1:0]     iss_b_i,
    output logic                                         redirect_o,
    output pipe_types_pkg::pc_t                          redirect_pc_o,
    output logic                  [`ISSUE_WIDTH-1:0]     fwd_ex_valid_o,
    output pipe_types_pkg::reg_addr_t [`ISSUE_WIDTH-1:0] fwd_ex_rd_o,
    output pipe_types_pkg::data_t [`ISSUE_WIDTH-1:0]     fwd_ex_data_o,
    output logic                  [`ISSUE_WIDTH-1:0]     fwd_wb_valid_o,
    output pipe_types_pkg::reg_addr_t [`ISSUE_WIDTH-1:0] fwd_wb_rd_o,
    output pipe_types_pkg::data_t [`ISSUE_WIDTH-1:0]     fwd_wb_data_o,
    output logic                  [`ISSUE_WIDTH-1:0]     wb_valid_o,
    output pipe_types_pkg::reg_addr_t [`ISSUE_WIDTH-1:0] wb_rd_o,
    output pipe_types_pkg::data_t [`ISSUE_WIDTH-1:0]     wb_data_o,
    output pipe_types_pkg::pc_t   [`ISSUE_WIDTH-1:0]     wb_pc_o
);

    pipe_types_pkg::data_t [`ISSUE_WIDTH-1:0] result;
    pipe_types_pkg::pc_t   [`ISSUE_WIDTH-1:0] target;
    logic                  [`ISSUE_WIDTH-1:0] taken;
    logic                  [`ISSUE_WIDTH-1:0] lane_live;
    logic                  [`ISSUE_WIDTH-1:0] lane_wr;

    for (genvar l = 0; l < `ISSUE_WIDTH; l++) begin : g_lane
        lane_alu u_lane_alu (
            .valid_i  (iss_valid_i[l]),
            .op_i     (iss_op_i[l]),
            .a_i      (iss_a_i[l]),
            .b_i      (iss_b_i[l]),
            .pc_i     (iss_pc_i[l]),
            .imm_i    (iss_imm_i[l]),
            .result_o (result[l]),
            .taken_o  (taken[l]),
            .target_o (target[l])
        );

        assign lane_wr[l]        = lane_live[l] && alu_op_pkg::writes_reg(iss_op_i[l]);
        assign fwd_ex_valid_o[l] = lane_wr[l];
        assign fwd_ex_rd_o[l]    = iss_rd_i[l];
        assign fwd_ex_data_o[l]  = result[l];
    end

    // a taken older branch kills the younger lane
    assign lane_live[0] = iss_valid_i[0];
    assign lane_live[1] = iss_valid_i[1] && !taken[0];

    assign redirect_o    = (taken[0] || taken[1]) && !pause_i;
    assign redirect_pc_o = taken[0] ? target[0] : (taken[1] ? target[1] : '0);

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            wb_valid_o <= '0;
            wb_rd_o    <= '0;
            wb_data_o  <= '0;
            wb_pc_o    <= '0;
        end else if (!pause_i) begin
            for (int l = 0; l < `ISSUE_WIDTH; l++) begin
                wb_valid_o[l] <= lane_live[l];
                // non-writing ops retire with rd 0 so writeback skips them
                wb_rd_o[l]    <= lane_wr[l] ? iss_rd_i[l] : '0;
                wb_data_o[l]  <= result[l];
                wb_pc_o[l]    <= iss_pc_i[l];
            end
        end
    end

    assign fwd_wb_valid_o = wb_valid_o;
    assign fwd_wb_rd_o    = wb_rd_o;
    assign fwd_wb_data_o  = wb_data_o;

endmodule

/* issue_stage.sv */
`timescale 1ns/1ps
`include "ex_cfg.svh"

module issue_stage (
    input  logic                                             clk,
    input  logic                                             rst_i,
    input  logic                                             pause_i,
    input  logic                                             flush_i,
    input  logic                                             redirect_i,
    input  logic                  [`ISSUE_WIDTH-1:0]         in_valid_i,
    input  alu_op_pkg::alu_op_t   [`ISSUE_WIDTH-1:0]         in_op_i,
    input  pipe_types_pkg::reg_addr_t [`ISSUE_WIDTH-1:0]     in_rd_i,
    input  pipe_types_pkg::reg_addr_t [`ISSUE_WIDTH-1:0]     in_rs1_i,
    input  pipe_types_pkg::reg_addr_t [`ISSUE_WIDTH-1:0]     in_rs2_i,
    input  pipe_types_pkg::data_t [`ISSUE_WIDTH-1:0]         in_imm_i,
    input  pipe_types_pkg::pc_t   [`ISSUE_WIDTH-1:0]         in_pc_i,
    input  pipe_types_pkg::data_t [2*`ISSUE_WIDTH-1:0]       rf_rdata_i,
    input  logic                  [`ISSUE_WIDTH-1:0]         fwd_ex_valid_i,
    input  pipe_types_pkg::reg_addr_t [`ISSUE_WIDTH-1:0]     fwd_ex_rd_i,
    input  pipe_types_pkg::data_t [`ISSUE_WIDTH-1:0]         fwd_ex_data_i,
    input  logic                  [`ISSUE_WIDTH-1:0]         fwd_wb_valid_i,
    input  pipe_types_pkg::reg_addr_t [`ISSUE_WIDTH-1:0]     fwd_wb_rd_i,
    input  pipe_types_pkg::data_t [`ISSUE_WIDTH-1:0]         fwd_wb_data_i,
    output pipe_types_pkg::reg_addr_t [2*`ISSUE_WIDTH-1:0]   rf_raddr_o,
    output logic                  [`ISSUE_WIDTH-1:0]         iss_valid_o,
    output alu_op_pkg::alu_op_t   [`ISSUE_WIDTH-1:0]         iss_op_o,
    output pipe_types_pkg::reg_addr_t [`ISSUE_WIDTH-1:0]     iss_rd_o,
    output pipe_types_pkg::pc_t   [`ISSUE_WIDTH-1:0]         iss_pc_o,
    output pipe_types_pkg::data_t [`ISSUE_WIDTH-1:0]         iss_imm_o,
    output pipe_types_pkg::data_t [`ISSUE_WIDTH-1:0]         iss_a_o,
    output pipe_types_pkg::data_t [`ISSUE_WIDTH-1:0]         iss_b_o
);

    pipe_types_pkg::data_t [`ISSUE_WIDTH-1:0] opnd_a;
    pipe_types_pkg::data_t [`ISSUE_WIDTH-1:0] opnd_b;

    // younger lane wins inside each stage, nearer stage wins over farther
    function automatic pipe_types_pkg::data_t bypass(input pipe_types_pkg::reg_addr_t addr,
                                                     input pipe_types_pkg::data_t rf_val);
        pipe_types_pkg::data_t val;
        if (addr == '0) begin
            val = '0;
        end else if (fwd_ex_valid_i[1] && fwd_ex_rd_i[1] == addr) begin
            val = fwd_ex_data_i[1];
        end else if (fwd_ex_valid_i[0] && fwd_ex_rd_i[0] == addr) begin
            val = fwd_ex_data_i[0];
        end else if (fwd_wb_valid_i[1] && fwd_wb_rd_i[1] == addr) begin
            val = fwd_wb_data_i[1];
        end else if (fwd_wb_valid_i[0] && fwd_wb_rd_i[0] == addr) begin
            val = fwd_wb_data_i[0];
        end else begin
            val = rf_val;
        end
        return val;
    endfunction

    always_comb begin
        for (int l = 0; l < `ISSUE_WIDTH; l++) begin
            rf_raddr_o[2*l]   = in_rs1_i[l];
            rf_raddr_o[2*l+1] = in_rs2_i[l];
            opnd_a[l] = bypass(in_rs1_i[l], rf_rdata_i[2*l]);
            if (in_op_i[l] inside {alu_op_pkg::ADDI, alu_op_pkg::LUI}) begin
                opnd_b[l] = in_imm_i[l];
            end else begin
                opnd_b[l] = bypass(in_rs2_i[l], rf_rdata_i[2*l+1]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || flush_i || redirect_i) begin
            iss_valid_o <= '0;
            iss_op_o    <= {`ISSUE_WIDTH{alu_op_pkg::NOP}};
            iss_rd_o    <= '0;
            iss_pc_o    <= '0;
            iss_imm_o   <= '0;
            iss_a_o     <= '0;
            iss_b_o     <= '0;
        end else if (!pause_i) begin
            iss_valid_o <= in_valid_i;
            iss_op_o    <= in_op_i;
            iss_rd_o    <= in_rd_i;
            iss_pc_o    <= in_pc_i;
            iss_imm_o   <= in_imm_i;
            iss_a_o     <= opnd_a;
            iss_b_o     <= opnd_b;
        end
    end

endmodule

/* lane_alu.sv */
`timescale 1ns/1ps
`include "ex_cfg.svh"

module lane_alu (
    input  logic                  valid_i,
    input  alu_op_pkg::alu_op_t   op_i,
    input  pipe_types_pkg::data_t a_i,
    input  pipe_types_pkg::data_t b_i,
    input  pipe_types_pkg::pc_t   pc_i,
    input  pipe_types_pkg::data_t imm_i,
    output pipe_types_pkg::data_t result_o,
    output logic                  taken_o,
    output pipe_types_pkg::pc_t   target_o
);

    logic [4:0] shamt;
    logic       lt_signed;

    assign shamt     = b_i[4:0];
    assign lt_signed = $signed(a_i) < $signed(b_i);

    always_comb begin
        case (op_i)
            alu_op_pkg::ADD: begin
                result_o = a_i + b_i;
            end
            alu_op_pkg::SUB: begin
                result_o = a_i - b_i;
            end
            alu_op_pkg::AND: begin
                result_o = a_i & b_i;
            end
            alu_op_pkg::OR: begin
                result_o = a_i | b_i;
            end
            alu_op_pkg::XOR: begin
                result_o = a_i ^ b_i;
            end
            alu_op_pkg::SLL: begin
                result_o = a_i << shamt;
            end
            alu_op_pkg::SRL: begin
                result_o = a_i >> shamt;
            end
            alu_op_pkg::SLT: begin
                result_o = pipe_types_pkg::data_t'(lt_signed);
            end
            alu_op_pkg::ADDI: begin
                result_o = a_i + b_i;
            end
            // b already carries the immediate here
            alu_op_pkg::LUI: begin
                result_o = {b_i[`DATA_W-13:0], 12'b0};
            end
            // branches and nop leave a zero result
            default: begin
                result_o = '0;
            end
        endcase
    end

    // compare on the resolved operands
    assign taken_o  = valid_i && alu_op_pkg::branch_taken(op_i, a_i, b_i);
    assign target_o = pc_i + imm_i;

endmodule

/* pipe_types_pkg.sv */
`include "ex_cfg.svh"

package pipe_types_pkg;

    // one datapath word, also used for immediates
    typedef logic [`DATA_W-1:0] data_t;

    // architectural register index
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // instruction address
    typedef logic [31:0] pc_t;

endpackage

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_dual_issue \
    -Mdir obj_dir -o sim_dual_issue > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/sim_dual_issue > sim.log 2>&1
run_status=$?
cat sim.log

if [ $run_status -ne 0 ]; then
    echo "simulation returned status $run_status"
    exit 1
fi

if grep -q "PASS: all tests" sim.log; then
    exit 0
fi

echo "pass line not found in sim.log"
exit 1

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

    // reset held for five rising edges
    initial begin
        rst_o = 1'b1;
        repeat (5) @(posedge clk_o);
        #10 rst_o = 1'b0;
    end

endmodule

/* tb_dual_issue.sv */
`timescale 1ns/1ps
`include "ex_cfg.svh"

module tb_dual_issue;

    logic clk;
    logic rst;
    logic pause;
    logic flush;
    logic                      [`ISSUE_WIDTH-1:0] in_valid;
    alu_op_pkg::alu_op_t       [`ISSUE_WIDTH-1:0] in_op;
    pipe_types_pkg::reg_addr_t [`ISSUE_WIDTH-1:0] in_rd;
    pipe_types_pkg::reg_addr_t [`ISSUE_WIDTH-1:0] in_rs1;
    pipe_types_pkg::reg_addr_t [`ISSUE_WIDTH-1:0] in_rs2;
    pipe_types_pkg::data_t     [`ISSUE_WIDTH-1:0] in_imm;
    pipe_types_pkg::pc_t       [`ISSUE_WIDTH-1:0] in_pc;
    logic                      [`ISSUE_WIDTH-1:0] commit_valid;
    pipe_types_pkg::reg_addr_t [`ISSUE_WIDTH-1:0] commit_rd;
    pipe_types_pkg::data_t     [`ISSUE_WIDTH-1:0] commit_data;
    pipe_types_pkg::pc_t       [`ISSUE_WIDTH-1:0] commit_pc;
    logic                                         redirect;
    pipe_types_pkg::pc_t                          redirect_pc;

    string                     stim_lines[$];
    pipe_types_pkg::reg_addr_t exp_rd[$];
    pipe_types_pkg::data_t     exp_data[$];
    pipe_types_pkg::pc_t       exp_pc[$];
    pipe_types_pkg::pc_t       exp_redir[$];
    int   commit_idx = 0;
    int   redir_idx = 0;
    logic stim_loaded = 1'b0;
    logic commit_fresh = 1'b0;

    tb_clock_gen u_tb_clock_gen (.clk_o(clk), .rst_o(rst));

    dual_issue_core u_dual_issue_core (
        .clk, .rst_i(rst), .in_valid_i(in_valid), .in_op_i(in_op), .in_rd_i(in_rd),
        .in_rs1_i(in_rs1), .in_rs2_i(in_rs2), .in_imm_i(in_imm), .in_pc_i(in_pc),
        .pause_i(pause), .flush_i(flush), .commit_valid_o(commit_valid),
        .commit_rd_o(commit_rd), .commit_data_o(commit_data), .commit_pc_o(commit_pc),
        .redirect_o(redirect), .redirect_pc_o(redirect_pc)
    );

    bind dual_issue_core dual_issue_properties u_dual_issue_properties (
        .clk, .rst_i, .pause_i, .flush_i, .redirect_i(redirect_o),
        .commit_valid_i(commit_valid_o), .iss_valid_i(iss_valid), .iss_op_i(iss_op),
        .wb_data_i(wb_data)
    );

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_data(input string name, input pipe_types_pkg::data_t exp,
                              input pipe_types_pkg::data_t got);
        if (got !== exp) begin
            $display("** Error @ %0t: %s expected %h got %h", $time, name, exp, got);
            abort_run();
        end
    endtask

    task automatic check_reg(input string name, input pipe_types_pkg::reg_addr_t exp,
                             input pipe_types_pkg::reg_addr_t got);
        if (got !== exp) begin
            $display("** Error @ %0t: %s expected %h got %h", $time, name, exp, got);
            abort_run();
        end
    endtask

    task automatic check_pc(input string name, input pipe_types_pkg::pc_t exp,
                            input pipe_types_pkg::pc_t got);
        if (got !== exp) begin
            $display("** Error @ %0t: %s expected %h got %h", $time, name, exp, got);
            abort_run();
        end
    endtask

    task automatic load_tests();
        int fd;
        string line;
        string body;
        pipe_types_pkg::reg_addr_t rd;
        pipe_types_pkg::data_t data;
        pipe_types_pkg::pc_t pc;
        fd = $fopen("dual_issue_tests.txt", "r");
        if (fd == 0) begin
            $display("Error: cannot open the test file");
            abort_run();
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 3) continue;
            body = line.substr(2, line.len() - 1);
            case (line.getc(0))
                "S": stim_lines.push_back(body);
                "C": begin
                    if ($sscanf(body, "%h %h %h", rd, data, pc) != 3) begin
                        $display("Error: malformed commit line in the test file");
                        abort_run();
                    end
                    exp_rd.push_back(rd);
                    exp_data.push_back(data);
                    exp_pc.push_back(pc);
                end
                "R": begin
                    if ($sscanf(body, "%h", pc) != 1) begin
                        $display("Error: malformed redirect line in the test file");
                        abort_run();
                    end
                    exp_redir.push_back(pc);
                end
                default: ;
            endcase
        end
        $fclose(fd);
    endtask

    task automatic drive_line(input string body);
        logic p, f, v0, v1;
        logic [3:0] op0, op1;
        pipe_types_pkg::reg_addr_t rd0, rs10, rs20, rd1, rs11, rs21;
        pipe_types_pkg::data_t imm0, imm1;
        pipe_types_pkg::pc_t pc0, pc1;
        int n;
        n = $sscanf(body, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    p, f, v0, op0, rd0, rs10, rs20, imm0, pc0,
                    v1, op1, rd1, rs11, rs21, imm1, pc1);
        if (n != 16) begin
            $display("Error: malformed stimulus line in the test file");
            abort_run();
        end
        pause = p;
        flush = f;
        in_valid = {v1, v0};
        in_op[0] = alu_op_pkg::alu_op_t'(op0);
        in_op[1] = alu_op_pkg::alu_op_t'(op1);
        in_rd = {rd1, rd0};
        in_rs1 = {rs11, rs10};
        in_rs2 = {rs21, rs20};
        in_imm = {imm1, imm0};
        in_pc = {pc1, pc0};
    endtask

    // commit outputs only carry new bundles after an unpaused edge
    always @(posedge clk) begin
        commit_fresh <= !pause;
    end

    always @(negedge clk) begin
        if (commit_fresh) begin
            for (int l = 0; l < `ISSUE_WIDTH; l++) begin
                if (commit_valid[l]) begin
                    if (commit_idx >= exp_rd.size()) begin
                        $display("Error: more commits than expected at %0t", $time);
                        abort_run();
                    end
                    check_reg("commit_rd_o", exp_rd[commit_idx], commit_rd[l]);
                    check_data("commit_data_o", exp_data[commit_idx], commit_data[l]);
                    check_pc("commit_pc_o", exp_pc[commit_idx], commit_pc[l]);
                    commit_idx++;
                end
            end
        end
        if (redirect) begin
            if (redir_idx >= exp_redir.size()) begin
                $display("Error: unexpected redirect at %0t", $time);
                abort_run();
            end
            check_pc("redirect_pc_o", exp_redir[redir_idx], redirect_pc);
            redir_idx++;
        end
    end

    initial begin
        wait (stim_loaded);
        #((stim_lines.size() + 20) * 100);
        $display("Error: simulation timed out before all commits arrived");
        abort_run();
    end

    initial begin
        pause = 1'b0;
        flush = 1'b0;
        in_valid = '0;
        in_op = {`ISSUE_WIDTH{alu_op_pkg::NOP}};
        in_rd = '0;
        in_rs1 = '0;
        in_rs2 = '0;
        in_imm = '0;
        in_pc = '0;
        load_tests();
        stim_loaded = 1'b1;
        #1;
        wait (rst == 1'b0);
        foreach (stim_lines[i]) begin
            @(posedge clk);
            #10;
            drive_line(stim_lines[i]);
        end
        @(posedge clk);
        #10;
        pause = 1'b0;
        flush = 1'b0;
        in_valid = '0;
        // last bundle commits two unpaused edges after it is accepted
        repeat (3) @(posedge clk);
        if (commit_idx == exp_rd.size() && redir_idx == exp_redir.size()) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("Error: commit or redirect count does not match the expected list");
            abort_run();
        end
    end

endmodule

/* writeback_stage.sv */
`timescale 1ns/1ps
`include "ex_cfg.svh"

module writeback_stage (
    input  logic                                           clk,
    input  logic                                           rst_i,
    input  logic                                           pause_i,
    input  logic                                           flush_i,
    input  logic                  [`ISSUE_WIDTH-1:0]       wb_valid_i,
    input  pipe_types_pkg::reg_addr_t [`ISSUE_WIDTH-1:0]   wb_rd_i,
    input  pipe_types_pkg::data_t [`ISSUE_WIDTH-1:0]       wb_data_i,
    input  pipe_types_pkg::pc_t   [`ISSUE_WIDTH-1:0]       wb_pc_i,
    input  pipe_types_pkg::reg_addr_t [2*`ISSUE_WIDTH-1:0] rf_raddr_i,
    output pipe_types_pkg::data_t [2*`ISSUE_WIDTH-1:0]     rf_rdata_o,
    output logic                  [`ISSUE_WIDTH-1:0]       commit_valid_o,
    output pipe_types_pkg::reg_addr_t [`ISSUE_WIDTH-1:0]   commit_rd_o,
    output pipe_types_pkg::data_t [`ISSUE_WIDTH-1:0]       commit_data_o,
    output pipe_types_pkg::pc_t   [`ISSUE_WIDTH-1:0]       commit_pc_o
);

    pipe_types_pkg::data_t rf [`REG_COUNT];
    logic [`ISSUE_WIDTH-1:0] we;

    for (genvar l = 0; l < `ISSUE_WIDTH; l++) begin : g_we
        assign we[l] = wb_valid_i[l] && wb_rd_i[l] != '0 && !pause_i && !flush_i && !rst_i;
    end

    // later lane in the loop overwrites, so lane 1 wins on a clash
    always_ff @(posedge clk) begin
        for (int l = 0; l < `ISSUE_WIDTH; l++) begin
            if (we[l]) begin
                rf[wb_rd_i[l]] <= wb_data_i[l];
            end
        end
    end

    always_comb begin
        for (int p = 0; p < 2*`ISSUE_WIDTH; p++) begin
            if (rf_raddr_i[p] == '0) begin
                rf_rdata_o[p] = '0;
            end else if (we[1] && wb_rd_i[1] == rf_raddr_i[p]) begin
                rf_rdata_o[p] = wb_data_i[1];
            end else if (we[0] && wb_rd_i[0] == rf_raddr_i[p]) begin
                rf_rdata_o[p] = wb_data_i[0];
            end else begin
                rf_rdata_o[p] = rf[rf_raddr_i[p]];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            commit_valid_o <= '0;
            commit_rd_o    <= '0;
            commit_data_o  <= '0;
            commit_pc_o    <= '0;
        end else if (!pause_i) begin
            commit_valid_o <= wb_valid_i;
            commit_rd_o    <= wb_rd_i;
            commit_data_o  <= wb_data_i;
            commit_pc_o    <= wb_pc_i;
        end
    end

endmodule
